// File: common/rvv_cfg_pkg.sv
package rvv_cfg_pkg;

    // Vector register geometry, SEW 8 and LMUL 1
    localparam int VLEN       = 128;
    localparam int SEW        = 8;
    localparam int NUM_ELEM   = VLEN / SEW;
    localparam int NUM_VREG   = 32;
    localparam int VREG_IDX_W = $clog2(NUM_VREG);

    // Command queue sizing
    localparam int CQ_DEPTH   = 4;
    localparam int CQ_PTR_W   = $clog2(CQ_DEPTH);

    typedef logic [VLEN-1:0]       vreg_t;
    typedef logic [VREG_IDX_W-1:0] vreg_idx_t;
    typedef logic [SEW-1:0]        elem_t;

endpackage

// File: common/rvv_uop_pkg.sv
package rvv_uop_pkg;

    typedef enum logic [1:0] {
        OP_VADD_VV = 2'd0,
        OP_VSUB_VV = 2'd1,
        OP_VADD_VX = 2'd2,
        OP_VMV_VX  = 2'd3
    } rvv_op_e;

    // Command as it arrives from the scalar core
    typedef struct packed {
        rvv_op_e               op;
        rvv_cfg_pkg::vreg_idx_t vd;
        rvv_cfg_pkg::vreg_idx_t vs1;
        rvv_cfg_pkg::vreg_idx_t vs2;
        rvv_cfg_pkg::elem_t     scalar;
    } rvv_cmd_t;

    // Issued request with operands already read from the VRF
    typedef struct packed {
        rvv_op_e               op;
        rvv_cfg_pkg::vreg_idx_t vd;
        rvv_cfg_pkg::vreg_t     a;
        rvv_cfg_pkg::vreg_t     b;
        rvv_cfg_pkg::elem_t     scalar;
    } alu_req_t;

    // Result on its way to the VRF
    typedef struct packed {
        rvv_cfg_pkg::vreg_idx_t vd;
        rvv_cfg_pkg::vreg_t     data;
    } rt_res_t;

endpackage

// File: rtl/rvv_alu.sv
`timescale 1ns/1ps

module rvv_alu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  rvv_uop_pkg::alu_req_t req,
    output logic                  req_ready,
    output logic                  res_valid,
    output rvv_uop_pkg::rt_res_t  res,
    input  logic                  res_ready
);
    import rvv_cfg_pkg::*;
    import rvv_uop_pkg::*;

    logic      s1_valid;
    rvv_op_e   s1_op;
    vreg_idx_t s1_vd;
    vreg_t     s1_a;
    vreg_t     s1_b;
    logic      s2_adv;
    vreg_t     s2_data;

    function automatic elem_t calc_elem(rvv_op_e op, elem_t a, elem_t b);
        case (op)
            OP_VSUB_VV: calc_elem = a - b;
            OP_VMV_VX:  calc_elem = b;
            default:    calc_elem = a + b;
        endcase
    endfunction

    assign s2_adv    = !res_valid || res_ready;
    assign req_ready = !s1_valid || s2_adv;

    // Per-element results, carries stay inside each byte
    always_comb begin
        for (int i = 0; i < NUM_ELEM; i++)
            s2_data[i*SEW +: SEW] = calc_elem(s1_op, s1_a[i*SEW +: SEW], s1_b[i*SEW +: SEW]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (req_ready)
                s1_valid <= req_valid;
            if (s2_adv)
                res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready && req_valid) begin
            s1_op <= req.op;
            s1_vd <= req.vd;
            s1_a  <= req.a;
            if (req.op == OP_VADD_VV || req.op == OP_VSUB_VV)
                s1_b <= req.b;
            else
                s1_b <= {NUM_ELEM{req.scalar}};
        end
        if (s2_adv && s1_valid) begin
            res.vd   <= s1_vd;
            res.data <= s2_data;
        end
    end

    res_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res)
    ) else $error("ALU result changed while stalled");

endmodule

// File: rtl/rvv_backend.sv
`timescale 1ns/1ps

module rvv_backend (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  rvv_uop_pkg::rvv_cmd_t cmd,
    output logic                  cmd_ready,
    output logic                  rt_valid,
    output rvv_uop_pkg::rt_res_t  rt,
    input  logic                  rt_ready,
    output logic                  idle
);
    import rvv_cfg_pkg::*;
    import rvv_uop_pkg::*;

    logic      head_valid;
    rvv_cmd_t  head;
    logic      head_pop;
    logic      cq_empty;

    vreg_idx_t rd_idx_a;
    vreg_idx_t rd_idx_b;
    vreg_t     rd_data_a;
    vreg_t     rd_data_b;

    logic      req_valid;
    alu_req_t  req;
    logic      req_ready;

    logic      res_valid;
    rt_res_t   res;
    logic      res_ready;

    logic      wr_en;
    rt_res_t   wr_res;
    logic      sb_busy;

    rvv_cmd_queue u_cmd_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .head_valid (head_valid),
        .head       (head),
        .head_pop   (head_pop),
        .empty      (cq_empty)
    );

    rvv_issue_ctrl u_issue_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head       (head),
        .head_pop   (head_pop),
        .rd_idx_a   (rd_idx_a),
        .rd_idx_b   (rd_idx_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .wr_en      (wr_en),
        .wr_res     (wr_res),
        .busy       (sb_busy)
    );

    rvv_vrf u_vrf (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_res    (wr_res)
    );

    rvv_alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    rvv_retire u_retire (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready),
        .rt_valid  (rt_valid),
        .rt        (rt),
        .rt_ready  (rt_ready),
        .wr_en     (wr_en),
        .wr_res    (wr_res)
    );

    // Scoreboard bits stay set until the result leaves, so they cover the pipeline
    assign idle = cq_empty && !sb_busy && !rt_valid;

endmodule

// File: rtl/rvv_cmd_queue.sv
`timescale 1ns/1ps

module rvv_cmd_queue (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  rvv_uop_pkg::rvv_cmd_t cmd,
    output logic                  cmd_ready,
    output logic                  head_valid,
    output rvv_uop_pkg::rvv_cmd_t head,
    input  logic                  head_pop,
    output logic                  empty
);
    import rvv_cfg_pkg::*;
    import rvv_uop_pkg::*;

    rvv_cmd_t            mem [CQ_DEPTH];
    logic [CQ_PTR_W-1:0] wr_ptr;
    logic [CQ_PTR_W-1:0] rd_ptr;
    logic [CQ_PTR_W:0]   count;
    logic [CQ_PTR_W:0]   count_nxt;
    logic                push;

    assign push      = cmd_valid && cmd_ready;
    assign count_nxt = count + (CQ_PTR_W+1)'(push) - (CQ_PTR_W+1)'(head_pop);

    assign empty      = (count == '0);
    assign head_valid = !empty;
    assign head       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            cmd_ready <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (head_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count     <= count_nxt;
            // Registered so that ready stays low through reset
            cmd_ready <= (count_nxt != CQ_DEPTH);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= cmd;
    end

    pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n) head_pop |-> !empty)
        else $error("Command queue popped while empty");

endmodule

// File: rtl/rvv_issue_ctrl.sv
`timescale 1ns/1ps

module rvv_issue_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   head_valid,
    input  rvv_uop_pkg::rvv_cmd_t  head,
    output logic                   head_pop,
    output rvv_cfg_pkg::vreg_idx_t rd_idx_a,
    output rvv_cfg_pkg::vreg_idx_t rd_idx_b,
    input  rvv_cfg_pkg::vreg_t     rd_data_a,
    input  rvv_cfg_pkg::vreg_t     rd_data_b,
    output logic                   req_valid,
    output rvv_uop_pkg::alu_req_t  req,
    input  logic                   req_ready,
    input  logic                   wr_en,
    input  rvv_uop_pkg::rt_res_t   wr_res,
    output logic                   busy
);
    import rvv_cfg_pkg::*;
    import rvv_uop_pkg::*;

    // One pending-write bit per vector register
    logic [NUM_VREG-1:0] sb;
    logic                need_vs1;
    logic                need_vs2;
    logic                hazard;
    logic                issue;

    always_comb begin
        need_vs1 = (head.op == OP_VADD_VV) || (head.op == OP_VSUB_VV);
        need_vs2 = (head.op != OP_VMV_VX);
    end

    // vd is checked too, a second pending write would clear the bit too early
    assign hazard = sb[head.vd]
                 || (need_vs1 && sb[head.vs1])
                 || (need_vs2 && sb[head.vs2]);

    assign issue    = head_valid && req_ready && !hazard;
    assign head_pop = issue;

    assign rd_idx_a = head.vs2;
    assign rd_idx_b = head.vs1;

    assign busy = |sb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sb <= '0;
        end else begin
            if (wr_en)
                sb[wr_res.vd] <= 1'b0;
            if (issue)
                sb[head.vd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else if (issue) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    // Operands captured in the issue cycle
    always_ff @(posedge clk) begin
        if (issue) begin
            req.op     <= head.op;
            req.vd     <= head.vd;
            req.a      <= rd_data_a;
            req.b      <= rd_data_b;
            req.scalar <= head.scalar;
        end
    end

    write_without_pending: assert property (
        @(posedge clk) disable iff (!rst_n) wr_en |-> sb[wr_res.vd]
    ) else $error("Write to v%0d with no pending scoreboard bit", $sampled(wr_res.vd));

endmodule

// File: rtl/rvv_retire.sv
`timescale 1ns/1ps

module rvv_retire (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 res_valid,
    input  rvv_uop_pkg::rt_res_t res,
    output logic                 res_ready,
    output logic                 rt_valid,
    output rvv_uop_pkg::rt_res_t rt,
    input  logic                 rt_ready,
    output logic                 wr_en,
    output rvv_uop_pkg::rt_res_t wr_res
);

    assign res_ready = !rt_valid || rt_ready;

    // VRF and scoreboard update on the outside transfer
    assign wr_en  = rt_valid && rt_ready;
    assign wr_res = rt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rt_valid <= 1'b0;
        end else if (res_ready) begin
            rt_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_ready && res_valid)
            rt <= res;
    end

    rt_held: assert property (
        @(posedge clk) disable iff (!rst_n) rt_valid && !rt_ready |=> rt_valid
    ) else $error("rt_valid dropped without a transfer");

endmodule

// File: rtl/rvv_vrf.sv
`timescale 1ns/1ps

module rvv_vrf (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rvv_cfg_pkg::vreg_idx_t rd_idx_a,
    input  rvv_cfg_pkg::vreg_idx_t rd_idx_b,
    output rvv_cfg_pkg::vreg_t     rd_data_a,
    output rvv_cfg_pkg::vreg_t     rd_data_b,
    input  logic                   wr_en,
    input  rvv_uop_pkg::rt_res_t   wr_res
);
    import rvv_cfg_pkg::*;

    vreg_t vreg [NUM_VREG];

    assign rd_data_a = vreg[rd_idx_a];
    assign rd_data_b = vreg[rd_idx_b];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VREG; i++)
                vreg[i] <= '0;
        end else if (wr_en) begin
            vreg[wr_res.vd] <= wr_res.data;
        end
    end

endmodule

// File: rvv_backend.f
common/rvv_cfg_pkg.sv
common/rvv_uop_pkg.sv
rtl/rvv_cmd_queue.sv
rtl/rvv_issue_ctrl.sv
rtl/rvv_vrf.sv
rtl/rvv_alu.sv
rtl/rvv_retire.sv
rtl/rvv_backend.sv
test/tb_rvv_backend.sv

// File: test/tb_rvv_backend.sv
`timescale 1ns/1ps

module tb_rvv_backend;
    import rvv_cfg_pkg::*;
    import rvv_uop_pkg::*;

    localparam int NUM_CMDS       = 4 + 3 + 3 + 5 + 60 + 12;
    localparam int TIMEOUT_CYCLES = 30 * NUM_CMDS + 200;
    // Output ready modes
    localparam int RT_HIGH = 0;
    localparam int RT_RAND = 1;
    localparam int RT_LOW  = 2;

    logic     clk;
    logic     rst_n;
    logic     cmd_valid;
    rvv_cmd_t cmd;
    logic     cmd_ready;
    logic     rt_valid;
    rt_res_t  rt;
    logic     rt_ready;
    logic     idle;

    vreg_t   model_vrf [NUM_VREG];
    rt_res_t exp_q [$];
    rt_res_t exp_head;
    int      exp_cnt;
    rt_res_t rt_prev;
    int      rt_mode;
    int      cycle_cnt;
    int      err_cnt;
    int      err_mark;
    int      pass_cnt;
    int      fail_cnt;
    int      test_num;
    logic    chk_reset;
    logic    chk_drained;
    logic    chk_full;

    rvv_backend i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rt_valid  (rt_valid),
        .rt        (rt),
        .rt_ready  (rt_ready),
        .idle      (idle)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        rt_prev <= rt;
        if (rst_n && rt_valid && rt_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            update_exp_view();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    rt_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && rt_ready |-> exp_cnt != 0)
    else begin
        $display("Result for v%0d retired with no command outstanding", $sampled(rt.vd));
        err_cnt++;
    end

    rt_value: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && rt_ready && exp_cnt != 0 |-> rt == exp_head)
    else begin
        $display("[ERROR] rt: expected %h, got %h", $sampled(exp_head), $sampled(rt));
        err_cnt++;
    end

    rt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && !rt_ready |=> rt_valid)
    else begin
        $display("rt_valid dropped while the result was still blocked");
        err_cnt++;
    end

    rt_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && !rt_ready |=> rt == rt_prev)
    else begin
        $display("[ERROR] rt: expected %h, got %h", $sampled(rt_prev), $sampled(rt));
        err_cnt++;
    end

    reset_state: assert property (@(posedge clk) disable iff (!rst_n)
        chk_reset |-> !rt_valid && idle && cmd_ready)
    else begin
        $display("[ERROR] rt_valid/idle/cmd_ready: expected 0/1/1, got %h/%h/%h",
                 $sampled(rt_valid), $sampled(idle), $sampled(cmd_ready));
        err_cnt++;
    end

    all_retired: assert property (@(posedge clk) disable iff (!rst_n)
        chk_drained |-> exp_cnt == 0)
    else begin
        $display("%0d expected results never retired", $sampled(exp_cnt));
        err_cnt++;
    end

    queue_fills: assert property (@(posedge clk) disable iff (!rst_n)
        chk_full |-> !cmd_ready)
    else begin
        $display("cmd_ready stayed high although the output was blocked");
        err_cnt++;
    end

    task automatic update_exp_view;
        exp_cnt  = exp_q.size();
        exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
    endtask

    // Every input change happens here, on the falling edge
    task automatic next_cycle;
        @(negedge clk);
        if (rt_mode == RT_RAND)
            rt_ready = (($urandom % 10) < 7);
        else
            rt_ready = (rt_mode == RT_HIGH);
    endtask

    function automatic vreg_t model_result(rvv_cmd_t c);
        vreg_t r;
        elem_t x;
        elem_t y;
        for (int i = 0; i < NUM_ELEM; i++) begin
            x = model_vrf[c.vs2][i*SEW +: SEW];
            y = model_vrf[c.vs1][i*SEW +: SEW];
            case (c.op)
                OP_VADD_VV: r[i*SEW +: SEW] = x + y;
                OP_VSUB_VV: r[i*SEW +: SEW] = x - y;
                OP_VADD_VX: r[i*SEW +: SEW] = x + c.scalar;
                default:    r[i*SEW +: SEW] = c.scalar;
            endcase
        end
        return r;
    endfunction

    task automatic send(input rvv_op_e op, input int vd, input int vs1, input int vs2,
                        input int scalar);
        rvv_cmd_t c;
        rt_res_t  e;
        c.op     = op;
        c.vd     = vreg_idx_t'(vd);
        c.vs1    = vreg_idx_t'(vs1);
        c.vs2    = vreg_idx_t'(vs2);
        c.scalar = elem_t'(scalar);
        cmd       = c;
        cmd_valid = 1'b1;
        while (!cmd_ready)
            next_cycle();
        // Accepted at the coming rising edge
        e.vd   = c.vd;
        e.data = model_result(c);
        model_vrf[c.vd] = e.data;
        exp_q.push_back(e);
        update_exp_view();
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle;
        while (!idle)
            next_cycle();
        chk_drained = 1'b1;
        next_cycle();
        chk_drained = 1'b0;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("Test %0d %s: PASS", test_num, name);
        end else begin
            fail_cnt++;
            $display("Test %0d %s: FAIL", test_num, name);
        end
        err_mark = err_cnt;
    endtask

    initial begin
        int n;
        void'($urandom(39));
        clk         = 1'b0;
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rt_ready    = 1'b1;
        rt_mode     = RT_HIGH;
        chk_reset   = 1'b0;
        chk_drained = 1'b0;
        chk_full    = 1'b0;
        for (int i = 0; i < NUM_VREG; i++)
            model_vrf[i] = '0;
        update_exp_view();
        repeat (3) next_cycle();
        rst_n = 1'b1;
        next_cycle();
        chk_reset = 1'b1;
        next_cycle();
        chk_reset = 1'b0;

        send(OP_VMV_VX, 1, 0, 0, 8'h5A);
        send(OP_VMV_VX, 2, 0, 0, 8'hA5);
        send(OP_VMV_VX, 3, 0, 0, 8'hFF);
        send(OP_VMV_VX, 4, 0, 0, 8'h01);
        wait_idle();
        end_test("reset and vmv.v.x");

        // 0xFF + 0x01 in every byte
        send(OP_VADD_VV, 5, 4, 3, 0);
        send(OP_VADD_VV, 6, 2, 1, 0);
        send(OP_VADD_VV, 7, 6, 5, 0);
        wait_idle();
        end_test("vadd.vv");

        send(OP_VSUB_VV, 8, 3, 4, 0);
        send(OP_VSUB_VV, 9, 2, 1, 0);
        send(OP_VADD_VX, 10, 0, 3, 8'h02);
        wait_idle();
        end_test("vsub.vv and vadd.vx");

        send(OP_VADD_VX, 11, 0, 4, 8'h10);
        send(OP_VADD_VV, 12, 11, 11, 0);
        send(OP_VSUB_VV, 13, 4, 12, 0);
        send(OP_VADD_VX, 14, 0, 13, 8'h80);
        send(OP_VADD_VV, 15, 12, 14, 0);
        wait_idle();
        end_test("dependent chain");

        rt_mode = RT_RAND;
        for (int i = 0; i < 60; i++)
            send(rvv_op_e'($urandom % 4), $urandom % 32, $urandom % 32, $urandom % 32,
                 $urandom % 256);
        wait_idle();
        end_test("random commands");

        rt_mode  = RT_LOW;
        rt_ready = 1'b0;
        n = 0;
        while (n < 12 && cmd_ready) begin
            send(OP_VMV_VX, 16 + n, 0, 0, 3 * n + 1);
            n++;
        end
        chk_full = 1'b1;
        next_cycle();
        chk_full = 1'b0;
        rt_mode = RT_RAND;
        wait_idle();
        end_test("output back-pressure");

        $display("Summary: %0d passed, %0d failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
